// ==== obj_video.f ====
verilog/obj_table_pkg.sv
verilog/video_pkg.sv
verilog/obj_table_ram.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buf.sv
verilog/obj_video.sv
test/obj_video_checker.sv
test/obj_video_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the object engine testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module obj_video_tb \
    -f obj_video.f \
    -o obj_video_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/obj_video_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$out"; then
    exit 0
fi
exit 1

// ==== test/obj_video_checker.sv ====
// ------------------------------
// strobe assertions for scanner
// and draw engine, bound in
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module obj_video_checker (
    input logic clk,
    input logic rst,
    input logic dr_start,
    input logic dr_busy,
    input logic tbl_we,    // scanner scratch write
    input logic buf_wr     // draw engine pixel write
);

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> !dr_busy)
        else $error("dr_start seen while the draw engine is busy");

    a_start_pulse: assert property (@(posedge clk) disable iff (rst)
        dr_start |=> !dr_start)
        else $error("dr_start held for more than one cycle");

    a_we_pulse: assert property (@(posedge clk) disable iff (rst)
        tbl_we |=> !tbl_we)
        else $error("tbl_we held for more than one cycle");

    a_wr_busy: assert property (@(posedge clk) disable iff (rst)
        buf_wr |-> dr_busy)
        else $error("line buffer write outside a busy draw");

endmodule

// scanner and draw engine meet in the top
bind obj_video obj_video_checker chk_i (
    .clk(clk), .rst(rst), .dr_start(dr_start), .dr_busy(dr_busy),
    .tbl_we(tbl_we), .buf_wr(buf_wr)
);

`default_nettype wire

// ==== test/obj_video_golden.txt ====
# R rom_addr data | W table_addr data | C table_addr readback | L vrender flip
# S swap and sweep | P x pixel {prio,pal,color} | T test name
T empty_list
W 000 f000
L 050 0
S
T basic_draw
R 08100 1203
R 08101 45f6
W 008 f000
W 000 3010
W 001 0020
W 002 0004
W 003 0100
W 004 1512
L 010 0
P 020 951
P 021 952
P 023 953
P 024 954
P 025 955
S
T rejected_objects
W 000 5040
W 008 1030
W 010 f805
W 018 3010
W 019 0040
W 01a 0004
W 01b 0100
W 01c 1512
L 020 0
S
T hflip
R 00200 3021
R 001ff f054
W 008 f000
W 000 3010
W 001 0060
W 002 0004
W 003 8200
W 004 2a01
L 010 0
P 060 6a1
P 061 6a2
P 063 6a3
P 064 6a4
P 065 6a5
S
T scratch
R 10300 7f00
R 10301 11f0
R 10302 89f0
R 10304 af00
W 001 0080
W 002 0002
W 003 0300
W 004 0323
L 010 0
P 080 c37
S
L 011 0
P 080 c38
P 081 c39
S
C 007 0304
T screen_flip
L 0ce 1
P 080 c3a
S
T overlap
R 00400 1111
R 00401 f000
R 00410 22f0
W 001 00a0
W 003 0400
W 004 0100
W 008 3010
W 009 00a2
W 00a 0000
W 00b 0410
W 00c 0200
W 010 f000
L 010 0
P 0a0 011
P 0a1 011
P 0a2 022
P 0a3 022
S
T cleared_after_read
L 005 0
S

// ==== test/obj_video_tb.sv ====
// ------------------------------
// object engine testbench with
// golden file player, rom model
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module obj_video_tb;

    import obj_table_pkg::*;
    import video_pkg::*;

    localparam int OBJ_AW     = 7;
    localparam int ROM_AW     = 18;
    localparam int SWEEP_W    = 320;   // visible pixels checked
    localparam int LINE_CYC   = 512;
    localparam int IDLE_LIMIT = 2000;

    logic              clk;
    logic              rst;
    logic [OBJ_AW+2:0] cpu_addr;
    logic [15:0]       cpu_din;
    logic              cpu_we;
    logic [15:0]       cpu_dout;
    logic              hstart;
    logic [8:0]        vrender;
    logic              flip;
    logic [8:0]        hdump;
    logic [ROM_AW-1:0] rom_addr;
    logic [15:0]       rom_data;
    obj_pxl_t          obj_pxl;

    logic [15:0] rom [2**ROM_AW];
    logic [11:0] exp_pxl [SWEEP_W];  // zero unless a P record set it
    int          checks;
    int          errors;
    int          t_checks;
    int          t_errors;
    int          tests;
    logic        aborted;
    string       test_name;

    obj_video #(.OBJ_AW(OBJ_AW), .ROM_AW(ROM_AW)) obj_video_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // rom answers one cycle after the address
    always @(posedge clk) begin
        logic [ROM_AW-1:0] a;
        a = rom_addr;
        #2;
        rom_data = rom[a];
    end

    task automatic cpu_write(input logic [OBJ_AW+2:0] a, input logic [15:0] d);
        @(posedge clk);
        #2;
        cpu_addr = a;
        cpu_din  = d;
        cpu_we   = 1'b1;
        @(posedge clk);
        #2;
        cpu_we = 1'b0;
    endtask

    task automatic cpu_check(input logic [OBJ_AW+2:0] a, input logic [15:0] exp);
        logic [15:0] got;
        obj_word_e   w;
        w = obj_word_e'(a[2:0]);
        @(posedge clk);
        #2;
        cpu_addr = a;
        @(posedge clk);
        #1;
        got = cpu_dout;
        checks++;
        t_checks++;
        assert (got == exp) else begin
            $display("error cpu_dout addr=%h %s got %h exp %h", a, w.name(), got, exp);
            errors++;
            t_errors++;
        end
    endtask

    task automatic run_line(input logic [8:0] v, input logic f);
        @(posedge clk);
        #2;
        vrender = v;
        flip    = f;
        hstart  = 1'b1;
        @(posedge clk);
        #2;
        hstart = 1'b0;
        repeat (LINE_CYC) @(posedge clk);
    endtask

    task automatic wait_draw_idle(output logic ok);
        int n;
        n = 0;
        #1;
        while (obj_video_i.dr_busy && n < IDLE_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = !obj_video_i.dr_busy;
        if (!ok) $display("timeout: draw engine still busy after %0d cycles", IDLE_LIMIT);
    endtask

    // swap halves on an off-screen line, then read the new front half
    task automatic swap_and_sweep(input int width, input logic check, output logic ok);
        logic [11:0] got;
        logic [8:0]  xv;
        wait_draw_idle(ok);
        if (ok) begin
            @(posedge clk);
            #2;
            vrender = LAST_LINE + 9'd60;
            flip    = 1'b0;
            hdump   = '0;
            hstart  = 1'b1;
            @(posedge clk);
            #2;
            hstart = 1'b0;
            for (int x = 0; x < width; x++) begin
                @(posedge clk);
                #1;
                got = obj_pxl;
                xv  = x[8:0];
                if (check) begin
                    checks++;
                    t_checks++;
                    assert (got == exp_pxl[x]) else begin
                        $display("error obj_pxl x=%h got %h exp %h", xv, got, exp_pxl[x]);
                        errors++;
                        t_errors++;
                    end
                end
                #1;
                hdump = xv + 9'd1;
            end
        end
    endtask

    task automatic report_test;
        if (test_name != "") begin
            tests++;
            if (t_errors == 0) begin
                $display("test %s: %0d checks ok", test_name, t_checks);
            end else begin
                $display("test %s: %0d of %0d checks wrong", test_name, t_errors, t_checks);
            end
        end
    endtask

    initial begin
        string       line;
        string       body;
        int          fd;
        int          code;
        logic [31:0] a;
        logic [31:0] d;
        logic        ok;
        void'($urandom(32'h36d5));
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_din   = '0;
        cpu_we    = 1'b0;
        hstart    = 1'b0;
        vrender   = '0;
        flip      = 1'b0;
        hdump     = '0;
        rom_data  = '0;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        t_checks  = 0;
        t_errors  = 0;
        aborted   = 1'b0;
        test_name = "";
        for (int i = 0; i < 2**ROM_AW; i++) begin
            rom[i] = 16'hf00f | {4'h0, i[7:0] ^ i[15:8] ^ {6'd0, i[17:16]}, 4'h0};
        end
        for (int i = 0; i < SWEEP_W; i++) exp_pxl[i] = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        #1;
        checks++;
        assert (obj_pxl == 12'h000) else begin
            $display("error obj_pxl after reset got %h exp %h", obj_pxl, 12'h000);
            errors++;
        end

        // junk in the whole table, then an end marker at entry 0
        for (int i = 0; i < 2**(OBJ_AW+3); i++) cpu_write(i[OBJ_AW+2:0], 16'($urandom()));
        cpu_write({7'd0, WORD_VZONE}, {END_BOTTOM, 8'h00});
        swap_and_sweep(512, 1'b0, ok);
        if (!ok) aborted = 1'b1;
        swap_and_sweep(512, 1'b0, ok);
        if (!ok) aborted = 1'b1;

        fd = $fopen("test/obj_video_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            while (line.len() > 0 && (line.getc(line.len() - 1) == 8'd10 ||
                                      line.getc(line.len() - 1) == 8'd13)) begin
                line = line.substr(0, line.len() - 2);
            end
            if (line.len() == 0 || line.getc(0) == "#") continue;
            body = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
            a = '0;
            d = '0;
            code = $sscanf(body, "%h %h", a, d);
            case (line.getc(0))
                "R": rom[a[ROM_AW-1:0]] = d[15:0];
                "W": cpu_write(a[OBJ_AW+2:0], d[15:0]);
                "C": cpu_check(a[OBJ_AW+2:0], d[15:0]);
                "L": run_line(a[8:0], d[0]);
                "P": exp_pxl[a[8:0]] = d[11:0];
                "S": begin
                    swap_and_sweep(SWEEP_W, 1'b1, ok);
                    if (!ok) aborted = 1'b1;
                    for (int i = 0; i < SWEEP_W; i++) exp_pxl[i] = '0;
                end
                "T": begin
                    report_test();
                    test_name = body;
                    t_checks  = 0;
                    t_errors  = 0;
                end
                default: begin
                    $display("unknown golden record: %s", line);
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0) $fclose(fd);
        report_test();
        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0 && checks > 0 && !aborted) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // overall limit on run time
    initial begin
        #4000000;
        $display("timeout: simulation ran too long");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/obj_draw.sv ====
// ------------------------------
// graphics rom fetcher and
// pixel writer
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module obj_draw #(
    parameter int ROM_AW = 18
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dr_start,
    input  obj_table_pkg::draw_cmd_t dr_cmd,
    output logic                     dr_busy,
    output logic [ROM_AW-1:0]        rom_addr,
    input  logic [15:0]              rom_data,
    output logic                     buf_wr,
    output logic [8:0]               buf_x,
    output video_pkg::obj_pxl_t      buf_pxl
);

    typedef enum logic [1:0] {IDLE, FETCH, WAIT, PIXELS} draw_st_e;

    draw_st_e    st;
    logic [8:0]  x;         // x of nibble 0 of this word
    logic [14:0] ofs;
    logic        hflip;
    logic [2:0]  bank;
    logic [5:0]  pal;
    logic [1:0]  prio;
    logic [4:0]  cnt;       // words fetched so far
    logic [15:0] pix;       // nibble 0 in bits 3:0
    logic [3:0]  mask;      // nibbles left to write
    logic        end_seen;
    logic [15:0] word_n;
    logic [3:0]  draw_m;
    logic        seen_end;
    logic [1:0]  sel;
    logic [3:0]  mask_nx;

    assign word_n = hflip ? rom_data
                          : {rom_data[3:0], rom_data[7:4], rom_data[11:8], rom_data[15:12]};

    // opaque nibbles before the first 15
    always_comb begin
        logic [3:0] nib;
        seen_end = 1'b0;
        for (int i = 0; i < 4; i++) begin
            nib = word_n[4*i +: 4];
            if (nib == 4'hf) seen_end = 1'b1;
            draw_m[i] = !seen_end && (nib != 4'h0);
        end
    end

    always_comb begin
        if (mask[0])      sel = 2'd0;
        else if (mask[1]) sel = 2'd1;
        else if (mask[2]) sel = 2'd2;
        else              sel = 2'd3;
    end

    assign mask_nx  = mask & ~(4'b0001 << sel);
    assign dr_busy  = st != IDLE;
    assign rom_addr = ROM_AW'({bank, ofs});
    assign buf_wr   = st == PIXELS;
    assign buf_x    = x + {7'd0, sel};
    assign buf_pxl  = '{prio: prio, pal: pal, color: pix[{sel, 2'b00} +: 4]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st <= IDLE;
        end else begin
            case (st)
                IDLE:  if (dr_start) st <= FETCH;
                FETCH: st <= WAIT;
                WAIT: begin
                    if (draw_m != 4'd0)       st <= PIXELS;
                    else if (seen_end || &cnt) st <= IDLE;
                    else                       st <= FETCH;
                end
                PIXELS: begin
                    if (mask_nx == 4'd0) st <= (end_seen || &cnt) ? IDLE : FETCH;
                end
                default: st <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            IDLE: begin
                if (dr_start) begin
                    x     <= dr_cmd.xpos;
                    ofs   <= dr_cmd.offset[14:0];
                    hflip <= dr_cmd.offset[15];
                    bank  <= dr_cmd.bank;
                    pal   <= dr_cmd.pal;
                    prio  <= dr_cmd.prio;
                    cnt   <= '0;
                end
            end
            WAIT: begin
                pix      <= word_n;
                mask     <= draw_m;
                end_seen <= seen_end;
                if (draw_m == 4'd0) begin  // nothing to write, next word
                    ofs <= hflip ? ofs - 1'b1 : ofs + 1'b1;
                    x   <= x + 9'd4;
                    cnt <= cnt + 1'b1;
                end
            end
            PIXELS: begin
                mask <= mask_nx;
                if (mask_nx == 4'd0) begin
                    ofs <= hflip ? ofs - 1'b1 : ofs + 1'b1;
                    x   <= x + 9'd4;
                    cnt <= cnt + 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/obj_line_buf.sv ====
// ------------------------------
// double line buffer with
// read-and-clear readout
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module obj_line_buf (
    input  logic                clk,
    input  logic                rst,
    input  logic                hstart,
    // draw side
    input  logic                wr,
    input  logic [8:0]          wr_x,
    input  video_pkg::obj_pxl_t wr_pxl,
    // readout side
    input  logic [8:0]          hdump,
    output video_pkg::obj_pxl_t obj_pxl
);

    import video_pkg::*;

    obj_pxl_t half0 [2**BUF_AW];
    obj_pxl_t half1 [2**BUF_AW];
    logic     front;   // half on screen
    obj_pxl_t rd_pxl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            front <= 1'b0;
        end else if (hstart) begin
            front <= ~front;
        end
    end

    // each half takes one write per cycle
    always_ff @(posedge clk) begin
        if (front) begin
            half1[hdump] <= '0;  // cleared as it is shown
            if (wr) half0[wr_x] <= wr_pxl;
        end else begin
            half0[hdump] <= '0;
            if (wr) half1[wr_x] <= wr_pxl;
        end
    end

    assign rd_pxl = front ? half1[hdump] : half0[hdump];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj_pxl <= '0;
        end else begin
            obj_pxl <= rd_pxl;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/obj_scan.sv ====
// ------------------------------
// per-line object table walker
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module obj_scan #(
    parameter int OBJ_AW = 7
) (
    input  logic                     clk,
    input  logic                     rst,
    // table port
    output logic [OBJ_AW+2:0]        tbl_addr,
    input  logic [15:0]              tbl_dout,
    output logic [15:0]              tbl_din,
    output logic                     tbl_we,
    // draw commands
    output logic                     dr_start,
    input  logic                     dr_busy,
    output obj_table_pkg::draw_cmd_t dr_cmd,
    // video timing
    input  logic                     flip,
    input  logic                     hstart,
    input  logic [8:0]               vrender
);

    import obj_table_pkg::*;
    import video_pkg::*;

    // each state is named after the word it addresses
    typedef enum logic [2:0] {
        IDLE, ZONE, XPOS, PITCH, OFFSET, ATTR, SCRATCH, DRAW
    } scan_st_e;

    scan_st_e           st;
    obj_word_e          word;
    logic [OBJ_AW-1:0]  cur_obj;
    logic [7:0]         line;      // effective line of this walk
    logic               first;     // first line of the object
    logic               wb;        // scratch write still due
    logic [8:0]         xpos;
    logic signed [15:0] pitch;
    logic [15:0]        offset;
    logic [2:0]         bank;
    logic [1:0]         prio;
    logic [5:0]         pal;
    logic [8:0]         vrf;
    logic [7:0]         top;
    logic [7:0]         bottom;
    logic               inzone;
    logic               badobj;
    logic [15:0]        base;
    logic [15:0]        cur_ofs;

    assign vrf = flip ? LAST_LINE - vrender : vrender;

    always_comb begin
        case (st)
            XPOS:          word = WORD_XPOS;
            PITCH:         word = WORD_PITCH;
            OFFSET:        word = WORD_OFFSET;
            ATTR:          word = WORD_ATTR;
            SCRATCH, DRAW: word = WORD_SCRATCH;
            default:       word = WORD_VZONE;
        endcase
    end

    assign tbl_addr = {cur_obj, word};

    // zone word is on tbl_dout while in XPOS
    assign top    = tbl_dout[7:0];
    assign bottom = tbl_dout[15:8];
    assign inzone = (line >= top) && (bottom > line);
    assign badobj = top >= bottom;

    // scratch word is on tbl_dout in the first DRAW cycle
    assign base    = first ? offset : tbl_dout;
    assign cur_ofs = wb ? base : offset;
    assign tbl_din = base + $unsigned(pitch);
    assign tbl_we  = (st == DRAW) && wb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= IDLE;
            cur_obj  <= '0;
            line     <= '0;
            first    <= 1'b0;
            wb       <= 1'b0;
            dr_start <= 1'b0;
            dr_cmd   <= '0;
        end else begin
            dr_start <= 1'b0;
            case (st)
                IDLE: begin
                    cur_obj <= '0;
                    wb      <= 1'b0;
                    if (hstart && vrf <= LAST_LINE) begin
                        line <= vrf[7:0];
                        st   <= ZONE;
                    end
                end
                ZONE: st <= XPOS;  // word 0 on its way
                XPOS: begin
                    if (bottom >= END_BOTTOM) begin
                        st <= IDLE;  // end of list
                    end else if (!inzone || badobj) begin
                        if (&cur_obj) begin
                            st <= IDLE;
                        end else begin
                            cur_obj <= cur_obj + 1'b1;
                            st      <= ZONE;
                        end
                    end else begin
                        first <= top == line;
                        st    <= PITCH;
                    end
                end
                PITCH: begin
                    xpos <= tbl_dout[8:0];
                    st   <= OFFSET;
                end
                OFFSET: begin
                    pitch <= tbl_dout;
                    st    <= ATTR;
                end
                ATTR: begin
                    offset <= tbl_dout;
                    st     <= SCRATCH;
                end
                SCRATCH: begin
                    pal  <= tbl_dout[13:8];
                    bank <= tbl_dout[6:4];
                    prio <= tbl_dout[1:0];
                    wb   <= 1'b1;
                    st   <= DRAW;
                end
                DRAW: begin
                    wb     <= 1'b0;
                    offset <= cur_ofs;  // hold across a stall
                    if (!dr_busy) begin
                        dr_start <= 1'b1;
                        dr_cmd   <= '{xpos: xpos, offset: cur_ofs, bank: bank,
                                      prio: prio, pal: pal};
                        if (&cur_obj) begin
                            st <= IDLE;
                        end else begin
                            cur_obj <= cur_obj + 1'b1;
                            st      <= ZONE;
                        end
                    end
                end
                default: st <= IDLE;
            endcase
            if (hstart && st != IDLE) begin
                st <= IDLE;  // line ran out of time
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/obj_table_pkg.sv ====
// ------------------------------
// object table entry layout, word
// index enum and draw command
// ------------------------------
`default_nettype none

package obj_table_pkg;

    // eight words per entry, six of them in use
    typedef enum logic [2:0] {
        WORD_VZONE   = 3'd0,  // bottom 15:8, top 7:0
        WORD_XPOS    = 3'd1,  // 8:0
        WORD_PITCH   = 3'd2,  // signed row step in rom words
        WORD_OFFSET  = 3'd3,  // 15 hflip, 14:0 rom word
        WORD_ATTR    = 3'd4,  // pal 13:8, bank 6:4, prio 1:0
        WORD_SCRATCH = 3'd7   // running row offset
    } obj_word_e;

    localparam logic [7:0] END_BOTTOM = 8'hf0;  // list terminator

    // one object on one line
    typedef struct packed {
        logic [8:0]  xpos;
        logic [15:0] offset;  // msb is hflip
        logic [2:0]  bank;
        logic [1:0]  prio;
        logic [5:0]  pal;
    } draw_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/obj_table_ram.sv ====
// ------------------------------
// dual-port object table ram
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module obj_table_ram #(
    parameter int OBJ_AW = 7
) (
    input  logic              clk,
    // cpu side
    input  logic [OBJ_AW+2:0] a_addr,
    input  logic [15:0]       a_din,
    input  logic              a_we,
    output logic [15:0]       a_dout,
    // scanner side
    input  logic [OBJ_AW+2:0] b_addr,
    input  logic [15:0]       b_din,
    input  logic              b_we,
    output logic [15:0]       b_dout
);

    localparam int WORDS = 2 ** (OBJ_AW + 3);

    logic [15:0] mem [WORDS];
    logic        clash;

    assign clash = a_we && (a_addr == b_addr);  // cpu keeps the word

    always_ff @(posedge clk) begin
        if (b_we && !clash) begin
            mem[b_addr] <= b_din;
        end
        if (a_we) begin
            mem[a_addr] <= a_din;
        end
    end

    // read-before-write on both ports
    always_ff @(posedge clk) begin
        a_dout <= mem[a_addr];
        b_dout <= mem[b_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/obj_video.sv ====
// ------------------------------
// object engine top level
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module obj_video #(
    parameter int OBJ_AW = 7,
    parameter int ROM_AW = 18
) (
    input  logic                clk,
    input  logic                rst,
    // cpu port
    input  logic [OBJ_AW+2:0]   cpu_addr,
    input  logic [15:0]         cpu_din,
    input  logic                cpu_we,
    output logic [15:0]         cpu_dout,
    // video timing
    input  logic                hstart,
    input  logic [8:0]          vrender,
    input  logic                flip,
    input  logic [8:0]          hdump,
    // graphics rom
    output logic [ROM_AW-1:0]   rom_addr,
    input  logic [15:0]         rom_data,
    output video_pkg::obj_pxl_t obj_pxl
);

    import obj_table_pkg::*;
    import video_pkg::*;

    logic [OBJ_AW+2:0] tbl_addr;
    logic [15:0]       tbl_din;
    logic [15:0]       tbl_dout;
    logic              tbl_we;
    logic              dr_start;
    logic              dr_busy;
    draw_cmd_t         dr_cmd;
    logic              buf_wr;
    logic [8:0]        buf_x;
    obj_pxl_t          buf_pxl;

    obj_table_ram #(.OBJ_AW(OBJ_AW)) table_i (
        .clk(clk),
        .a_addr(cpu_addr), .a_din(cpu_din), .a_we(cpu_we), .a_dout(cpu_dout),
        .b_addr(tbl_addr), .b_din(tbl_din), .b_we(tbl_we), .b_dout(tbl_dout)
    );

    obj_scan #(.OBJ_AW(OBJ_AW)) scan_i (
        .clk(clk), .rst(rst),
        .tbl_addr(tbl_addr), .tbl_dout(tbl_dout), .tbl_din(tbl_din), .tbl_we(tbl_we),
        .dr_start(dr_start), .dr_busy(dr_busy), .dr_cmd(dr_cmd),
        .flip(flip), .hstart(hstart), .vrender(vrender)
    );

    obj_draw #(.ROM_AW(ROM_AW)) draw_i (
        .clk(clk), .rst(rst),
        .dr_start(dr_start), .dr_cmd(dr_cmd), .dr_busy(dr_busy),
        .rom_addr(rom_addr), .rom_data(rom_data),
        .buf_wr(buf_wr), .buf_x(buf_x), .buf_pxl(buf_pxl)
    );

    obj_line_buf line_buf_i (
        .clk(clk), .rst(rst), .hstart(hstart),
        .wr(buf_wr), .wr_x(buf_x), .wr_pxl(buf_pxl),
        .hdump(hdump), .obj_pxl(obj_pxl)
    );

endmodule

`default_nettype wire

// ==== verilog/video_pkg.sv ====
// ------------------------------
// line timing constants and the
// object pixel struct
// ------------------------------
`default_nettype none

package video_pkg;

    localparam logic [8:0] LAST_LINE = 9'd223;  // last visible line

    localparam int BUF_AW = 9;  // line buffer x width

    // pixel as stored in the line buffer, zero means empty
    typedef struct packed {
        logic [1:0] prio;
        logic [5:0] pal;
        logic [3:0] color;
    } obj_pxl_t;

endpackage

`default_nettype wire
